// ==== rtl/cpuPkg.sv ====
package cpuPkg;

  localparam int DataWidth = 32;
  localparam int RegIndexWidth = 8;  // widest register field in the instruction word

  typedef logic [DataWidth-1:0] word_t;

  // ====================================================================
  // opcodes kept from the original numbering
  // ====================================================================
  typedef enum logic [5:0] {
    opMove        = 6'd1,
    opLoadImm     = 6'd2,
    opLoadInd     = 6'd3,
    opLoadOff     = 6'd4,
    opLoadAbs     = 6'd6,
    opStoreAbs    = 6'd7,
    opStoreOff    = 6'd8,
    opPush        = 6'd11,
    opPop         = 6'd12,
    opCmpReg      = 6'd13,
    opCmpImm      = 6'd14,
    opSetEq       = 6'd15,
    opSetNe       = 6'd16,
    opSetLt       = 6'd17,
    opSetGt       = 6'd18,
    opJump        = 6'd19,
    opJumpNotEq   = 6'd20,
    opJumpEq      = 6'd21,
    opJumpZero    = 6'd22,
    opJumpNonZero = 6'd23,
    opAddImm      = 6'd28,
    opAddReg      = 6'd29,
    opSubImm      = 6'd30,
    opSubReg      = 6'd31,
    opInc         = 6'd33,
    opDec         = 6'd34,
    opShl         = 6'd35,
    opShr         = 6'd36,
    opNeg         = 6'd37,
    opDebugOut    = 6'd47
  } opcode_t;

  typedef enum logic [1:0] {
    memError = 2'd0,
    memBusy  = 2'd1,
    memDone  = 2'd2
  } memStatus_t;

  typedef enum logic [1:0] {
    haltNone,
    haltFetchError,
    haltDataError,
    haltIllegal
  } haltCode_t;

  typedef struct packed {
    opcode_t                  op;
    logic [RegIndexWidth-1:0] regA;
    logic [RegIndexWidth-1:0] regB;
    logic [RegIndexWidth-1:0] regC;
    word_t                    dataWord;
    logic                     hasDataWord;
    logic                     illegal;
    logic                     fetchError;
  } decodedInstr_t;

  typedef struct packed {
    logic  write;
    word_t address;
    word_t writeData;
  } memRequest_t;

  typedef struct packed {
    word_t readData;
    logic  error;
  } memResult_t;

endpackage

// ==== rtl/aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit (
  input  cpuPkg::opcode_t op,
  input  cpuPkg::word_t   operandA,
  input  cpuPkg::word_t   operandB,
  input  cpuPkg::word_t   operandC,
  input  cpuPkg::word_t   dataWord,
  output cpuPkg::word_t   result,
  output cpuPkg::word_t   flags
);
  import cpuPkg::*;

  word_t cmpRhs;

  assign cmpRhs = (op == opCmpImm) ? dataWord : operandB;

  // upper bits of register 1 pass through
  assign flags = {operandC[DataWidth-1:3],
                  operandA > cmpRhs,
                  operandA < cmpRhs,
                  operandA == cmpRhs};

  always_comb begin
    case (op)
      opMove:    result = operandB;
      opLoadImm: result = dataWord;
      opAddImm:  result = operandB + dataWord;
      opAddReg:  result = operandB + operandC;
      opSubImm:  result = operandB - dataWord;
      opSubReg:  result = operandB - operandC;
      opInc:     result = operandA + 32'd1;
      opDec:     result = operandA - 32'd1;
      opShl:     result = operandB << operandC;  // large counts give zero
      opShr:     result = operandB >> operandC;
      opNeg:     result = -operandB;
      opSetEq:   result = word_t'(operandB == operandC);
      opSetNe:   result = word_t'(operandB != operandC);
      opSetLt:   result = word_t'(operandB < operandC);
      opSetGt:   result = word_t'(operandB > operandC);
      default:   result = '0;
    endcase
  end

endmodule

// ==== rtl/regFile.sv ====
`timescale 1ns/1ps

module regFile #(
  parameter int RegCount = 16
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [$clog2(RegCount)-1:0] rdIndexA,
  input  logic [$clog2(RegCount)-1:0] rdIndexB,
  input  logic [$clog2(RegCount)-1:0] rdIndexC,
  output cpuPkg::word_t               rdDataA,
  output cpuPkg::word_t               rdDataB,
  output cpuPkg::word_t               rdDataC,
  input  logic                        wrEnable,
  input  logic [$clog2(RegCount)-1:0] wrIndex,
  input  cpuPkg::word_t               wrData
);
  import cpuPkg::*;

  word_t regs [RegCount];  // r0 stack pointer, r1 flags

  assign rdDataA = regs[rdIndexA];
  assign rdDataB = regs[rdIndexB];
  assign rdDataC = regs[rdIndexC];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < RegCount; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEnable) begin
      regs[wrIndex] <= wrData;
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    wrEnable |-> !$isunknown(wrIndex) && wrIndex < RegCount);

endmodule

// ==== rtl/instrFetch.sv ====
`timescale 1ns/1ps

module instrFetch (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  fetchReq,
  input  cpuPkg::word_t         fetchPc,
  output logic                  fetchAck,
  output cpuPkg::decodedInstr_t instr,
  output logic                  fetchMemReq,
  output cpuPkg::memRequest_t   fetchMemOp,
  input  logic                  fetchMemAck,
  input  cpuPkg::memResult_t    fetchMemResult
);
  import cpuPkg::*;

  typedef enum logic [1:0] {fsWait, fsReadInstr, fsReadData, fsPresent} fetchState_t;

  fetchState_t state;
  opcode_t     rawOp;
  logic        kept;
  logic        needsData;
  word_t       word;

  assign word  = fetchMemResult.readData;
  assign rawOp = opcode_t'(word[5:0]);

  // opcode classes
  always_comb begin
    kept = 1'b1;
    needsData = 1'b0;
    case (rawOp)
      opLoadImm, opLoadOff, opLoadAbs, opStoreAbs, opStoreOff, opCmpImm,
      opJump, opJumpNotEq, opJumpEq, opJumpZero, opJumpNonZero,
      opAddImm, opSubImm:
        needsData = 1'b1;
      opMove, opLoadInd, opPush, opPop, opCmpReg, opSetEq, opSetNe, opSetLt,
      opSetGt, opAddReg, opSubReg, opInc, opDec, opShl, opShr, opNeg, opDebugOut:
        needsData = 1'b0;
      default:
        kept = 1'b0;  // dropped or unknown
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= fsWait;
      fetchAck <= 1'b0;
      fetchMemReq <= 1'b0;
    end else begin
      case (state)
        fsWait: if (fetchReq && !fetchMemAck) begin
          fetchMemReq <= 1'b1;
          state <= fsReadInstr;
        end
        fsReadInstr: if (fetchMemAck) begin
          fetchMemReq <= 1'b0;
          if (!fetchMemResult.error && kept && needsData) begin
            state <= fsReadData;
          end else begin
            fetchAck <= 1'b1;
            state <= fsPresent;
          end
        end
        fsReadData: begin
          if (fetchMemReq && fetchMemAck) begin
            fetchMemReq <= 1'b0;
            fetchAck <= 1'b1;
            state <= fsPresent;
          end else if (!fetchMemReq && !fetchMemAck) begin
            fetchMemReq <= 1'b1;  // second word once the first ack is gone
          end
        end
        fsPresent: if (!fetchReq) begin
          fetchAck <= 1'b0;
          state <= fsWait;
        end
        default: state <= fsWait;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      fsWait: fetchMemOp <= '{write: 1'b0, address: fetchPc, writeData: '0};
      fsReadInstr: if (fetchMemAck) begin
        fetchMemOp.address <= fetchPc + 32'd4;
        instr.op <= rawOp;
        instr.regA <= word[15:8];
        instr.regB <= word[23:16];
        instr.regC <= word[31:24];
        instr.dataWord <= '0;
        instr.hasDataWord <= needsData;
        instr.illegal <= !kept && !fetchMemResult.error;
        instr.fetchError <= fetchMemResult.error;
      end
      fsReadData: if (fetchMemReq && fetchMemAck) begin
        instr.dataWord <= word;
        instr.fetchError <= fetchMemResult.error;
      end
      default: ;
    endcase
  end

endmodule

// ==== rtl/memPort.sv ====
`timescale 1ns/1ps

module memPort (
  input  logic               clk,
  input  logic               rst,
  input  logic               fetchMemReq,
  input  cpuPkg::memRequest_t fetchMemOp,
  output logic               fetchMemAck,
  output cpuPkg::memResult_t fetchMemResult,
  input  logic               lsMemReq,
  input  cpuPkg::memRequest_t lsMemOp,
  output logic               lsMemAck,
  output cpuPkg::memResult_t lsMemResult,
  output logic               memReadReq,
  output logic               memWriteReq,
  output cpuPkg::word_t      memAddress,
  output cpuPkg::word_t      memWriteData,
  input  cpuPkg::memStatus_t memStatus,
  input  cpuPkg::word_t      memReadData
);
  import cpuPkg::*;

  typedef enum logic [1:0] {mpIdle, mpWait, mpAck} portState_t;

  portState_t  state;
  logic        servingLs;  // which link owns the current transaction
  memRequest_t op;
  memResult_t  result;

  assign op = lsMemReq ? lsMemOp : fetchMemOp;
  assign fetchMemResult = result;
  assign lsMemResult = result;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= mpIdle;
      memReadReq <= 1'b0;
      memWriteReq <= 1'b0;
      fetchMemAck <= 1'b0;
      lsMemAck <= 1'b0;
    end else begin
      memReadReq <= 1'b0;  // single cycle pulses
      memWriteReq <= 1'b0;
      case (state)
        mpIdle: if (fetchMemReq || lsMemReq) begin
          memReadReq <= !op.write;
          memWriteReq <= op.write;
          state <= mpWait;
        end
        mpWait: if (memStatus == memDone || memStatus == memError) begin
          fetchMemAck <= !servingLs;
          lsMemAck <= servingLs;
          state <= mpAck;
        end
        mpAck: if (!(servingLs ? lsMemReq : fetchMemReq)) begin
          fetchMemAck <= 1'b0;
          lsMemAck <= 1'b0;
          state <= mpIdle;
        end
        default: state <= mpIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == mpIdle) begin
      servingLs <= lsMemReq;
      memAddress <= op.address;
      memWriteData <= op.writeData;
    end
    if (state == mpWait) begin
      result <= '{readData: memReadData, error: memStatus == memError};
    end
  end

  // fetch and execute never compete for memory
  assert property (@(posedge clk) disable iff (rst) !(fetchMemReq && lsMemReq));

endmodule

// ==== rtl/execUnit.sv ====
`timescale 1ns/1ps

module execUnit #(
  parameter int            RegCount = 16,
  parameter cpuPkg::word_t ResetPc  = '0
) (
  input  logic                        clk,
  input  logic                        rst,
  output logic                        fetchReq,
  output cpuPkg::word_t               fetchPc,
  input  logic                        fetchAck,
  input  cpuPkg::decodedInstr_t       instr,
  output logic                        lsMemReq,
  output cpuPkg::memRequest_t         lsMemOp,
  input  logic                        lsMemAck,
  input  cpuPkg::memResult_t          lsMemResult,
  output logic [$clog2(RegCount)-1:0] rdIndexA,
  output logic [$clog2(RegCount)-1:0] rdIndexB,
  output logic [$clog2(RegCount)-1:0] rdIndexC,
  input  cpuPkg::word_t               rdDataA,
  input  cpuPkg::word_t               rdDataB,
  input  cpuPkg::word_t               rdDataC,
  output logic                        wrEnable,
  output logic [$clog2(RegCount)-1:0] wrIndex,
  output cpuPkg::word_t               wrData,
  output cpuPkg::word_t               debugOut,
  output logic                        debugValid,
  output logic                        halted,
  output cpuPkg::haltCode_t           haltCode,
  output cpuPkg::word_t               instrPointer
);
  import cpuPkg::*;

  localparam int IdxW = $clog2(RegCount);

  typedef enum logic [2:0] {stIdle, stFetching, stExecuting, stMemory, stHalted} execState_t;

  execState_t    state;
  decodedInstr_t cur;
  word_t         aluResult;
  word_t         aluFlags;
  word_t         nextIp;
  word_t         stackPtr;
  word_t         memAddr;
  word_t         storeData;
  logic          isStore;
  logic          isMemOp;
  logic          writesReg;
  logic          jumpTaken;

  aluUnit alu_i (
    .op(cur.op),
    .operandA(rdDataA),
    .operandB(rdDataB),
    .operandC(rdDataC),
    .dataWord(cur.dataWord),
    .result(aluResult),
    .flags(aluFlags)
  );

  assign fetchPc = instrPointer;
  assign halted = (state == stHalted);
  assign nextIp = instrPointer + (cur.hasDataWord ? 32'd8 : 32'd4);
  assign stackPtr = rdDataC;

  assign isStore = cur.op inside {opStoreAbs, opStoreOff, opPush};
  assign isMemOp = isStore || (cur.op inside {opLoadInd, opLoadOff, opLoadAbs, opPop});
  assign writesReg = cur.op inside {opMove, opLoadImm, opAddImm, opAddReg, opSubImm, opSubReg,
                                    opSetEq, opSetNe, opSetLt, opSetGt,
                                    opInc, opDec, opShl, opShr, opNeg};

  // ====================================================================
  // operand, address and branch selection
  // ====================================================================
  assign rdIndexA = cur.regA[IdxW-1:0];
  assign rdIndexB = cur.regB[IdxW-1:0];

  always_comb begin
    case (cur.op)
      opCmpReg, opCmpImm, opJumpEq, opJumpNotEq: rdIndexC = IdxW'(1);  // flags
      opPush, opPop: rdIndexC = '0;                                     // stack pointer
      default: rdIndexC = cur.regC[IdxW-1:0];
    endcase
  end

  always_comb begin
    memAddr = cur.dataWord;
    storeData = rdDataB;
    case (cur.op)
      opLoadInd: memAddr = rdDataB;
      opLoadOff: memAddr = cur.dataWord + rdDataB;
      opStoreOff: memAddr = cur.dataWord + rdDataA;
      opPush: begin
        memAddr = stackPtr;
        storeData = rdDataA;
      end
      opPop: memAddr = stackPtr - 32'd4;
      default: ;
    endcase
  end

  always_comb begin
    case (cur.op)
      opJump: jumpTaken = 1'b1;
      opJumpEq: jumpTaken = rdDataC[0];
      opJumpNotEq: jumpTaken = !rdDataC[0];
      opJumpZero: jumpTaken = (rdDataA == '0);
      opJumpNonZero: jumpTaken = (rdDataA != '0);
      default: jumpTaken = 1'b0;
    endcase
  end

  // ====================================================================
  // write back
  // ====================================================================
  always_comb begin
    wrEnable = 1'b0;
    wrIndex = rdIndexA;
    wrData = aluResult;
    if (state == stExecuting) begin
      if (cur.op inside {opCmpReg, opCmpImm}) begin
        wrEnable = 1'b1;
        wrIndex = IdxW'(1);
        wrData = aluFlags;
      end else if (cur.op inside {opPush, opPop}) begin
        wrEnable = 1'b1;  // stack pointer moves before the access completes
        wrIndex = '0;
        wrData = (cur.op == opPush) ? stackPtr + 32'd4 : stackPtr - 32'd4;
      end else begin
        wrEnable = writesReg;
      end
    end else if (state == stMemory && lsMemReq && lsMemAck) begin
      wrEnable = !isStore && !lsMemResult.error;
      wrData = lsMemResult.readData;
    end
  end

  // ====================================================================
  // sequencer
  // ====================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= stIdle;
      fetchReq <= 1'b0;
      lsMemReq <= 1'b0;
      debugValid <= 1'b0;
      debugOut <= '0;
      haltCode <= haltNone;
      instrPointer <= ResetPc;
    end else begin
      debugValid <= 1'b0;
      case (state)
        stIdle: if (!fetchAck) begin
          fetchReq <= 1'b1;
          state <= stFetching;
        end
        stFetching: if (fetchAck) begin
          fetchReq <= 1'b0;
          if (instr.fetchError) begin
            haltCode <= haltFetchError;
            state <= stHalted;
          end else if (instr.illegal) begin
            haltCode <= haltIllegal;
            state <= stHalted;
          end else begin
            state <= stExecuting;
          end
        end
        stExecuting: begin
          if (isMemOp) begin
            lsMemReq <= 1'b1;
            state <= stMemory;
          end else begin
            if (cur.op == opDebugOut) begin
              debugOut <= rdDataA;
              debugValid <= 1'b1;
            end
            instrPointer <= jumpTaken ? cur.dataWord : nextIp;
            state <= stIdle;
          end
        end
        stMemory: if (lsMemAck) begin
          lsMemReq <= 1'b0;
          if (lsMemResult.error) begin
            haltCode <= haltDataError;
            state <= stHalted;
          end else begin
            instrPointer <= nextIp;
            state <= stIdle;
          end
        end
        default: ;  // halted until reset
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == stFetching && fetchAck) cur <= instr;
    if (state == stExecuting) begin
      lsMemOp <= '{write: isStore, address: memAddr, writeData: storeData};
    end
  end

  // a halted core stays silent
  assert property (@(posedge clk) disable iff (rst)
    halted |-> !wrEnable && !lsMemReq && !fetchReq);

endmodule

// ==== rtl/cpuCore.sv ====
`timescale 1ns/1ps

module cpuCore #(
  parameter int            RegCount = 16,
  parameter cpuPkg::word_t ResetPc  = '0
) (
  input  logic                clk,
  input  logic                rst,
  output logic                memReadReq,
  output logic                memWriteReq,
  output cpuPkg::word_t       memAddress,
  output cpuPkg::word_t       memWriteData,
  input  cpuPkg::memStatus_t  memStatus,
  input  cpuPkg::word_t       memReadData,
  output cpuPkg::word_t       debugOut,
  output logic                debugValid,
  output logic                halted,
  output cpuPkg::haltCode_t   haltCode,
  output cpuPkg::word_t       instrPointer
);
  import cpuPkg::*;

  // fetch link
  logic          fetchReq;
  word_t         fetchPc;
  logic          fetchAck;
  decodedInstr_t instr;

  // memory links
  logic        fetchMemReq;
  memRequest_t fetchMemOp;
  logic        fetchMemAck;
  memResult_t  fetchMemResult;
  logic        lsMemReq;
  memRequest_t lsMemOp;
  logic        lsMemAck;
  memResult_t  lsMemResult;

  // register file ports
  logic [$clog2(RegCount)-1:0] rdIndexA, rdIndexB, rdIndexC, wrIndex;
  word_t                       rdDataA, rdDataB, rdDataC, wrData;
  logic                        wrEnable;

  instrFetch fetch_i (.*);

  execUnit #(.RegCount(RegCount), .ResetPc(ResetPc)) exec_i (.*);

  regFile #(.RegCount(RegCount)) regs_i (.*);

  memPort mem_i (.*);

endmodule

// ==== tests/memModel.sv ====
`timescale 1ns/1ps

module memModel (
  input  logic               clk,
  input  logic               rst,
  input  logic               memReadReq,
  input  logic               memWriteReq,
  input  cpuPkg::word_t      memAddress,
  input  cpuPkg::word_t      memWriteData,
  output cpuPkg::memStatus_t memStatus,
  output cpuPkg::word_t      memReadData
);
  import cpuPkg::*;

  localparam word_t ErrorBase = 32'h0000_F000;  // everything from here up answers memError
  localparam int    Words = ErrorBase / 4;

  word_t storage [Words];
  logic  pending;
  logic  pendingWrite;
  word_t pendingAddr;
  word_t pendingData;
  int    cyclesLeft;
  logic  sampledRst;
  logic  sampledRead;
  logic  sampledWrite;
  word_t sampledAddr;
  word_t sampledData;

  initial begin
    memStatus = memBusy;
    memReadData = '0;
    pending = 1'b0;
    cyclesLeft = 0;
  end

  // unwritten words read back as a function of their byte address
  task automatic fillPattern();
    for (int i = 0; i < Words; i++) begin
      storage[i] = word_t'(i * 4) ^ 32'hC3A5_0F1E;
    end
  endtask

  task automatic poke(input word_t address, input word_t data);
    storage[address[15:2]] = data;
  endtask

  function automatic word_t peek(input word_t address);
    return storage[address[15:2]];
  endfunction

  always @(posedge clk) begin
    sampledRst = rst;
    sampledRead = memReadReq;
    sampledWrite = memWriteReq;
    sampledAddr = memAddress;
    sampledData = memWriteData;
    #1;
    memStatus = memBusy;  // done and error last one cycle
    if (sampledRst) begin
      pending = 1'b0;
    end else if (sampledRead || sampledWrite) begin
      pending = 1'b1;
      pendingWrite = sampledWrite;
      pendingAddr = sampledAddr;
      pendingData = sampledData;
      cyclesLeft = $urandom % 4 + 1;
    end else if (pending && cyclesLeft > 1) begin
      cyclesLeft--;
    end else if (pending) begin
      pending = 1'b0;
      if (pendingAddr >= ErrorBase) begin
        memStatus = memError;
      end else begin
        if (pendingWrite) storage[pendingAddr[15:2]] = pendingData;
        else memReadData = storage[pendingAddr[15:2]];
        memStatus = memDone;
      end
    end
  end

endmodule

// ==== tests/cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb;
  import cpuPkg::*;

  localparam int    RegCount = 16;
  localparam int    NumTests = 8;
  localparam word_t TrapAddr = 32'h0000_0400;   // wrong-path landing spot
  localparam word_t DataBase = 32'h0000_0800;
  localparam word_t StackBase = 32'h0000_0C00;
  localparam word_t ErrorBase = 32'h0000_F000;
  localparam word_t BadMark = 32'hDEAD_0000;
  localparam word_t GoodMark = 32'h600D_0000;

  logic       clk;
  logic       rst;
  logic       memReadReq;
  logic       memWriteReq;
  word_t      memAddress;
  word_t      memWriteData;
  memStatus_t memStatus;
  word_t      memReadData;
  word_t      debugOut;
  logic       debugValid;
  logic       halted;
  haltCode_t  haltCode;
  word_t      instrPointer;

  word_t observed[$];
  word_t expected[$];
  word_t asmPc;
  int    testErrors;
  int    testsPassed;
  int    testsFailed;
  logic  memOutstanding;
  logic  wrongPathCheck;

  cpuCore #(.RegCount(RegCount), .ResetPc(32'h0)) cpuCore_i (.*);

  memModel mem_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    #(NumTests * 64 * 10 * 20);
    $display("watchdog expired before all tests finished");
    $display("TEST FAIL");
    $finish;
  end

  always @(posedge clk) begin
    if (!rst && debugValid) observed.push_back(debugOut);
  end

  always @(posedge clk) begin
    if (rst) memOutstanding <= 1'b0;
    else if (memReadReq || memWriteReq) memOutstanding <= 1'b1;
    else if (memStatus == memDone || memStatus == memError) memOutstanding <= 1'b0;
  end

  // ====================================================================
  // memory port and halt checks
  // ====================================================================
  assert property (@(posedge clk) disable iff (rst)
    (memReadReq || memWriteReq) |=> !(memReadReq || memWriteReq))
    else begin
      $display("memory request held for more than one cycle");
      testErrors++;
    end

  assert property (@(posedge clk) disable iff (rst) !(memReadReq && memWriteReq))
    else begin
      $display("read and write requests raised together");
      testErrors++;
    end

  assert property (@(posedge clk) disable iff (rst)
    (memReadReq || memWriteReq) |-> !memOutstanding)
    else begin
      $display("new memory request before the previous one completed");
      testErrors++;
    end

  assert property (@(posedge clk) disable iff (rst) halted |-> !(memReadReq || memWriteReq))
    else begin
      $display("memory request issued while halted");
      testErrors++;
    end

  assert property (@(posedge clk) disable iff (rst) halted |=> halted && $stable(haltCode))
    else begin
      $display("halt state or halt code changed before reset");
      testErrors++;
    end

  assert property (@(posedge clk) disable iff (rst)
    (debugValid && wrongPathCheck) |-> debugOut[31:16] != BadMark[31:16])
    else begin
      $display("wrong-path marker %h was emitted", debugOut);
      testErrors++;
    end

  task automatic checkValue(input string signal, input word_t want, input word_t seen);
    assert (seen === want) else begin
      $display("CHECK FAILED %s expected %h actual %h", signal, want, seen);
      testErrors++;
    end
  endtask

  // ====================================================================
  // program assembly
  // ====================================================================
  function automatic word_t encode(input int op, input int a, input int b, input int c);
    return {c[7:0], b[7:0], a[7:0], 2'b00, op[5:0]};
  endfunction

  task automatic emit(input int op, input int a, input int b, input int c);
    mem_i.poke(asmPc, encode(op, a, b, c));
    asmPc += 4;
  endtask

  task automatic emitWithData(input int op, input int a, input int b, input int c,
                              input word_t data);
    emit(op, a, b, c);
    mem_i.poke(asmPc, data);
    asmPc += 4;
  endtask

  task automatic loadImm(input int r, input word_t value);
    emitWithData(opLoadImm, r, 0, 0, value);
  endtask

  task automatic showReg(input int r, input word_t value);
    emit(opDebugOut, r, 0, 0);
    expected.push_back(value);
  endtask

  task automatic emitMarker(input word_t value, input logic reached);
    loadImm(15, value);
    emit(opDebugOut, 15, 0, 0);
    if (reached) expected.push_back(value);
  endtask

  // taken jump skips the 12 byte bad marker right behind it
  task automatic jumpOverBad(input int op, input int a, input int mark);
    emitWithData(op, a, 0, 0, asmPc + 32'd20);
    emitMarker(BadMark + mark, 1'b0);
    emitMarker(GoodMark + mark, 1'b1);
  endtask

  task automatic jumpToTrap(input int op, input int a, input int mark);
    emitWithData(op, a, 0, 0, TrapAddr);  // must fall through
    emitMarker(GoodMark + mark, 1'b1);
  endtask

  task automatic emitStop(output word_t at);
    at = asmPc;
    emit(0, 0, 0, 0);  // opcode 0 is illegal
  endtask

  task automatic beginTest();
    @(posedge clk);
    #1 rst = 1'b1;
    mem_i.fillPattern();
    observed.delete();
    expected.delete();
    asmPc = '0;
    wrongPathCheck = 1'b0;
  endtask

  task automatic runToHalt(input haltCode_t code, input word_t haltAt);
    repeat (5) @(posedge clk);
    #1 rst = 1'b0;
    while (!halted) begin
      @(posedge clk);
    end
    repeat (20) @(posedge clk);  // bus must stay quiet meanwhile
    #1;
    checkValue("halted", 32'd1, word_t'(halted));
    checkValue("haltCode", word_t'(code), word_t'(haltCode));
    checkValue("instrPointer", haltAt, instrPointer);
    checkValue("debug count", expected.size(), observed.size());
    foreach (expected[i]) begin
      if (i < observed.size()) checkValue("debugOut", expected[i], observed[i]);
    end
  endtask

  task automatic report(input string name);
    if (testErrors == 0) begin
      testsPassed++;
      $display("%s: passed", name);
    end else begin
      testsFailed++;
      $display("%s: failed with %0d errors", name, testErrors);
    end
    testErrors = 0;
  endtask

  // ====================================================================
  // tests
  // ====================================================================
  task automatic movesAndImmediates();
    word_t first, second, haltAt;
    beginTest();
    first = $urandom;
    second = $urandom;
    loadImm(2, first);
    loadImm(3, second);
    emit(opMove, 4, 2, 0);
    emit(opMove, 5, 3, 0);
    showReg(4, first);
    showReg(5, second);
    emit(opMove, 2, 5, 0);
    showReg(2, second);
    loadImm(12, ~first);
    showReg(12, ~first);
    showReg(8'h13 % RegCount + 8'h10, second);  // upper field bits are ignored
    emitStop(haltAt);
    runToHalt(haltIllegal, haltAt);
    report("moves and immediates");
  endtask

  task automatic aluOps(input int round);
    word_t a, b, d, s, haltAt;
    beginTest();
    a = $urandom;
    b = $urandom;
    d = $urandom;
    s = $urandom % 40;
    if (round == 1) b = a;  // equal operands for the set-if ops
    loadImm(2, a);
    loadImm(3, b);
    loadImm(4, s);
    emitWithData(opAddImm, 5, 2, 0, d);
    showReg(5, a + d);
    emit(opAddReg, 5, 2, 3);
    showReg(5, a + b);
    emitWithData(opSubImm, 5, 2, 0, d);
    showReg(5, a - d);
    emit(opSubReg, 5, 2, 3);
    showReg(5, a - b);
    emit(opMove, 6, 2, 0);
    emit(opInc, 6, 0, 0);
    showReg(6, a + 32'd1);
    emit(opDec, 6, 0, 0);
    emit(opDec, 6, 0, 0);
    showReg(6, a - 32'd1);
    emit(opShl, 5, 2, 4);
    showReg(5, (s >= 32) ? 32'd0 : a << s);
    emit(opShr, 5, 2, 4);
    showReg(5, (s >= 32) ? 32'd0 : a >> s);
    emit(opNeg, 5, 2, 0);
    showReg(5, 32'd0 - a);
    emit(opMove, 7, 2, 0);
    emit(opSetEq, 5, 2, 7);
    showReg(5, 32'd1);
    emit(opSetEq, 5, 2, 3);
    showReg(5, a == b);
    emit(opSetNe, 5, 2, 3);
    showReg(5, a != b);
    emit(opSetLt, 5, 2, 3);
    showReg(5, a < b);
    emit(opSetGt, 5, 2, 3);
    showReg(5, a > b);
    emit(opSetLt, 5, 3, 2);
    showReg(5, b < a);
    emitStop(haltAt);
    runToHalt(haltIllegal, haltAt);
    report($sformatf("alu ops round %0d", round));
  endtask

  task automatic memoryAccess();
    word_t first, second, haltAt;
    beginTest();
    first = $urandom;
    second = $urandom;
    loadImm(2, first);
    loadImm(3, second);
    loadImm(6, 32'h10);
    loadImm(0, StackBase);  // stack pointer
    emitWithData(opStoreAbs, 0, 2, 0, DataBase);
    emitWithData(opStoreOff, 6, 3, 0, DataBase);
    emitWithData(opLoadAbs, 7, 0, 0, DataBase);
    showReg(7, first);
    loadImm(8, DataBase + 32'h10);
    emit(opLoadInd, 9, 8, 0);
    showReg(9, second);
    emitWithData(opLoadOff, 10, 6, 0, DataBase);
    showReg(10, second);
    emit(opPush, 2, 0, 0);
    emit(opPush, 3, 0, 0);
    emit(opPop, 11, 0, 0);
    emit(opPop, 12, 0, 0);
    showReg(11, second);
    showReg(12, first);
    showReg(0, StackBase);
    emitStop(haltAt);
    runToHalt(haltIllegal, haltAt);
    checkValue("mem[DataBase]", first, mem_i.peek(DataBase));
    checkValue("mem[DataBase+10]", second, mem_i.peek(DataBase + 32'h10));
    checkValue("mem[StackBase+4]", second, mem_i.peek(StackBase + 32'h4));
    report("memory access");
  endtask

  task automatic controlFlow();
    word_t haltAt;
    beginTest();
    wrongPathCheck = 1'b1;
    jumpOverBad(opJump, 0, 1);
    loadImm(2, 32'd5);
    loadImm(3, 32'd5);
    loadImm(4, 32'd9);
    emit(opCmpReg, 2, 3, 0);
    jumpOverBad(opJumpEq, 0, 2);
    jumpToTrap(opJumpNotEq, 0, 3);
    emit(opCmpReg, 2, 4, 0);
    showReg(1, 32'h2);  // 5 below 9
    jumpOverBad(opJumpNotEq, 0, 4);
    jumpToTrap(opJumpEq, 0, 5);
    emitWithData(opCmpImm, 4, 0, 0, 32'd9);
    jumpOverBad(opJumpEq, 0, 6);
    emitWithData(opCmpImm, 4, 0, 0, 32'd3);
    showReg(1, 32'h4);
    jumpOverBad(opJumpNotEq, 0, 7);
    loadImm(5, 32'd0);
    jumpOverBad(opJumpZero, 5, 8);
    jumpToTrap(opJumpNonZero, 5, 9);
    jumpToTrap(opJumpZero, 2, 10);
    jumpOverBad(opJumpNonZero, 2, 11);
    emitStop(haltAt);
    asmPc = TrapAddr;
    emitMarker(BadMark + 32'hFF, 1'b0);
    emit(0, 0, 0, 0);
    runToHalt(haltIllegal, haltAt);
    report("control flow");
  endtask

  task automatic dataErrorHalt();
    word_t value, haltAt;
    beginTest();
    value = $urandom;
    loadImm(2, value);
    showReg(2, value);
    haltAt = asmPc;
    emitWithData(opLoadAbs, 3, 0, 0, ErrorBase + 32'h20);
    emit(opDebugOut, 3, 0, 0);
    runToHalt(haltDataError, haltAt);
    report("data error halt");
  endtask

  task automatic fetchErrorHalt();
    word_t value;
    beginTest();
    value = $urandom;
    loadImm(2, value);
    showReg(2, value);
    emitWithData(opJump, 0, 0, 0, ErrorBase);
    emit(opDebugOut, 2, 0, 0);
    runToHalt(haltFetchError, ErrorBase);
    report("fetch error halt");
  endtask

  task automatic illegalOpHalt();
    word_t value, haltAt;
    beginTest();
    value = $urandom;
    loadImm(2, value);
    showReg(2, value);
    haltAt = asmPc;
    emit(38, 2, 0, 0);  // dropped opcode
    emit(opDebugOut, 2, 0, 0);
    runToHalt(haltIllegal, haltAt);
    report("illegal opcode halt");
  endtask

  initial begin
    void'($urandom(64));
    rst = 1'b1;
    asmPc = '0;
    testErrors = 0;
    testsPassed = 0;
    testsFailed = 0;
    wrongPathCheck = 1'b0;
    movesAndImmediates();
    aluOps(0);
    aluOps(1);
    memoryAccess();
    controlFlow();
    dataErrorHalt();
    fetchErrorHalt();
    illegalOpHalt();
    $display("tests run %0d, passed %0d, failed %0d",
             testsPassed + testsFailed, testsPassed, testsFailed);
    if (testsFailed == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
rtl/cpuPkg.sv
rtl/aluUnit.sv
rtl/regFile.sv
rtl/instrFetch.sv
rtl/memPort.sv
rtl/execUnit.sv
rtl/cpuCore.sv
tests/memModel.sv
tests/cpuTb.sv
